//--- testbench/pq_testdata.txt
// Priority queue operations, three hex words per entry: op key expected
// op 0 test start, 1 enqueue, 2 dequeue, 3 dequeue on empty, 4 ERR read,
// 5 ERR clear, 6 random fill of key entries, 7 drain, f end of list
0 0000 0000
1 0030 0000
1 0010 0000
1 ffff 0000
1 0010 0000
1 0000 0000
2 0000 0000
2 0000 0010
2 0000 0010
2 0000 0030
2 0000 ffff
0 0001 0000
1 0007 0000
2 0000 0007
1 0003 0000
1 0009 0000
2 0000 0003
1 0001 0000
1 0005 0000
2 0000 0001
2 0000 0005
2 0000 0009
0 0002 0000
6 0008 0000
1 1234 0001
4 0000 0001
7 0000 0000
0 0003 0000
3 0000 0001
4 0000 0003
5 0000 0000
4 0000 0000
0 0004 0000
6 0008 0000
7 0000 0000
6 0005 0000
7 0000 0000
f 0000 0000

//--- tb.f
+incdir+include
rtl/pq_pkg.sv
rtl/pq_apb_decode.sv
rtl/pq_value_router.sv
rtl/pq_node_ctrl.sv
rtl/pq_node.sv
rtl/pq_chain.sv
rtl/pq_result.sv
rtl/pq_top.sv
testbench/tb_pq_top.sv

//--- Bender.yml
package:
  name: pq

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/pq_pkg.sv
      - rtl/pq_apb_decode.sv
      - rtl/pq_value_router.sv
      - rtl/pq_node_ctrl.sv
      - rtl/pq_node.sv
      - rtl/pq_chain.sv
      - rtl/pq_result.sv
      - rtl/pq_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_pq_top.sv

//--- testbench/tb_pq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pq_defs.svh"

module tb_pq_top import pq_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int MAX_WAIT   = 16;
  localparam int MAX_LINES  = 64;
  // Cycle bound per data entry that covers a whole random fill
  localparam int OP_CYCLES  = `PQ_DEPTH * 12;

  logic                  clk = 1'b0;
  logic                  rst_n_i;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  apb_addr_t             paddr;
  key_t                  pwdata;
  logic [`PQ_APB_DW-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  logic [15:0] tdata [0:3*MAX_LINES-1];
  // Reference model keeps the keys in ascending order
  key_t        model [$];
  logic [1:0]  err_model;
  int          seed = 32'h1f9a_623e;
  int          n_lines;
  bit          loaded = 1'b0;
  int          checks;
  int          errors;
  int          test_errs;
  int          n_tests;
  int          waits;
  string       cur_test;

  always #(CLK_PERIOD/2) clk = ~clk;

  pq_top i_pq_top (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  ////////////////////
  // APB driver
  ////////////////////

  // Starts and ends on a falling edge
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input key_t wdata,
                          output logic [`PQ_APB_DW-1:0] rdata, output logic err,
                          output bit ok);
    int cycles;
    cycles  = 0;
    ok      = 1'b0;
    rdata   = '0;
    err     = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    while (!ok && cycles < MAX_WAIT) begin
      // Sample mid low phase
      #(CLK_PERIOD/4);
      if (pready === 1'b1) begin
        ok    = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end else begin
        cycles++;
      end
      @(negedge clk);
    end
    psel    = 1'b0;
    penable = 1'b0;
    waits  += cycles;
    if (!ok) begin
      errors++;
      test_errs++;
      $display("Transfer to offset %h in test %s got no pready within %0d cycles",
               addr, cur_test, MAX_WAIT);
    end
  endtask

  task automatic check_val(input string what, input logic [31:0] exp,
                           input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errs++;
      $display("ERROR %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic data_check(input int entry, input logic [31:0] file_exp,
                            input logic [31:0] model_exp);
    if (file_exp !== model_exp) begin
      errors++;
      test_errs++;
      $display("Test data entry %0d expects %h but the reference model gives %h",
               entry, file_exp, model_exp);
    end
  endtask

  ////////////////////
  // Register access
  ////////////////////

  task automatic check_status();
    logic [`PQ_APB_DW-1:0] rd;
    logic [`PQ_APB_DW-1:0] exp;
    logic                  err;
    bit                    ok;
    exp = '0;
    exp[7:0] = model.size();
    exp[`PQ_STAT_FULL_BIT]  = (model.size() == `PQ_DEPTH);
    exp[`PQ_STAT_EMPTY_BIT] = (model.size() == 0);
    apb_xfer(1'b0, `PQ_ADDR_STATUS, '0, rd, err, ok);
    if (ok) begin
      check_val("status pslverr", 0, err);
      check_val("status", exp[9:0], rd[9:0]);
    end
  endtask

  task automatic model_insert(input key_t key);
    int pos;
    pos = 0;
    while (pos < model.size() && model[pos] <= key) begin
      pos++;
    end
    model.insert(pos, key);
  endtask

  task automatic enqueue_key(input key_t key);
    logic [`PQ_APB_DW-1:0] rd;
    logic                  err;
    bit                    ok;
    bit                    exp_err;
    exp_err = (model.size() == `PQ_DEPTH);
    apb_xfer(1'b1, `PQ_ADDR_DATA, key, rd, err, ok);
    if (ok) begin
      check_val($sformatf("enqueue %h pslverr", key), exp_err, err);
    end
    if (exp_err) begin
      err_model[`PQ_ERR_FULL_BIT] = 1'b1;
    end else begin
      model_insert(key);
    end
    check_status();
  endtask

  task automatic dequeue_head();
    logic [`PQ_APB_DW-1:0] rd;
    logic                  err;
    bit                    ok;
    bit                    exp_err;
    exp_err = (model.size() == 0);
    apb_xfer(1'b0, `PQ_ADDR_DEQ, '0, rd, err, ok);
    if (ok) begin
      check_val("dequeue pslverr", exp_err, err);
      if (!exp_err) begin
        check_val("dequeue key", model[0], rd[`PQ_KEY_W-1:0]);
      end
    end
    if (exp_err) begin
      err_model[`PQ_ERR_EMPTY_BIT] = 1'b1;
    end else begin
      void'(model.pop_front());
    end
    check_status();
  endtask

  task automatic access_err(input logic wr);
    logic [`PQ_APB_DW-1:0] rd;
    logic                  err;
    bit                    ok;
    apb_xfer(wr, `PQ_ADDR_ERR, '0, rd, err, ok);
    if (ok) begin
      check_val("err pslverr", 0, err);
      if (!wr) begin
        check_val("err bits", err_model, rd[1:0]);
      end
    end
    if (wr) begin
      err_model = '0;
    end
  endtask

  ////////////////////
  // Test bookkeeping
  ////////////////////

  function automatic string test_name(input int idx);
    case (idx)
      0: return "sorting";
      1: return "interleave";
      2: return "full_error";
      3: return "empty_error";
      4: return "random";
      default: return $sformatf("test_%0d", idx);
    endcase
  endfunction

  task automatic finish_test();
    n_tests++;
    $display("Test %s finished with %0d errors", cur_test, test_errs);
  endtask

  task automatic begin_test(input int idx);
    finish_test();
    cur_test  = test_name(idx);
    test_errs = 0;
  endtask

  initial begin : main
    logic [15:0] op;
    logic [15:0] key;
    logic [15:0] exp;
    bit          exp_err;
    rst_n_i   = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    err_model = '0;
    checks    = 0;
    errors    = 0;
    test_errs = 0;
    n_tests   = 0;
    waits     = 0;
    cur_test  = "reset";
    // Unused entries read as end of list
    for (int i = 0; i < 3*MAX_LINES; i++) begin
      tdata[i] = 16'h000f;
    end
    $readmemh("testbench/pq_testdata.txt", tdata);
    n_lines = 0;
    while (n_lines < MAX_LINES && tdata[3*n_lines] !== 16'h000f) begin
      n_lines++;
    end
    loaded = 1'b1;
    repeat (10) @(negedge clk);
    rst_n_i = 1'b1;
    check_val("pready after reset", 0, pready);
    check_val("pslverr after reset", 0, pslverr);
    check_status();
    for (int ln = 0; ln < n_lines; ln++) begin
      op  = tdata[3*ln];
      key = tdata[3*ln+1];
      exp = tdata[3*ln+2];
      case (op)
        16'h0: begin_test(key);
        16'h1: begin
          data_check(ln, exp, model.size() == `PQ_DEPTH);
          enqueue_key(key);
        end
        16'h2, 16'h3: begin
          exp_err = (op == 16'h3);
          data_check(ln, exp_err, model.size() == 0);
          if (!exp_err && model.size() > 0) begin
            data_check(ln, exp, model[0]);
          end
          dequeue_head();
        end
        16'h4: begin
          data_check(ln, exp, err_model);
          access_err(1'b0);
        end
        16'h5: access_err(1'b1);
        16'h6: begin
          for (int i = 0; i < key; i++) begin
            enqueue_key(key_t'($random(seed)));
          end
        end
        16'h7: begin
          while (model.size() > 0) begin
            dequeue_head();
          end
        end
        default: begin
          errors++;
          test_errs++;
          $display("Test data entry %0d holds unknown operation %h", ln, op);
        end
      endcase
    end
    finish_test();
    $display("Tests %0d, checks %0d, errors %0d, wait states %0d",
             n_tests, checks, errors, waits);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Bound grows with the number of data entries
  initial begin : watchdog
    wait (loaded);
    #((n_lines + 12) * OP_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the run did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/pq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pq_defs.svh"

module pq_top import pq_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_n_i,
  input  wire                   psel_i,
  input  wire                   penable_i,
  input  wire                   pwrite_i,
  input  wire apb_addr_t        paddr_i,
  input  wire key_t             pwdata_i,
  output logic [`PQ_APB_DW-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  logic      enq_req;
  logic      deq_req;
  logic      err_clr;
  logic      op_err;
  apb_addr_t rd_sel;
  logic      op_ready;
  key_t      head_key;
  logic      head_valid;
  count_t    count;
  logic      full;
  logic      empty;

  ////////////////////
  // Decode
  ////////////////////

  pq_apb_decode i_decode (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .op_ready_i (op_ready),
    .full_i     (full),
    .empty_i    (empty),
    .enq_o      (enq_req),
    .deq_o      (deq_req),
    .err_clr_o  (err_clr),
    .rd_sel_o   (rd_sel),
    .pready_o   (pready_o),
    .op_err_o   (op_err)
  );

  ////////////////////
  // Execute
  ////////////////////

  pq_chain i_chain (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .enq_i        (enq_req),
    .deq_i        (deq_req),
    .enq_key_i    (pwdata_i),
    .op_ready_o   (op_ready),
    .head_key_o   (head_key),
    .head_valid_o (head_valid),
    .count_o      (count),
    .full_o       (full),
    .empty_o      (empty)
  );

  // Head valid must agree with the count seen by the decoder
  a_head_vs_count: assert property (@(posedge clk) disable iff (!rst_n_i)
    head_valid == !empty)
    else $error("head valid disagrees with count");

  ////////////////////
  // Result
  ////////////////////

  pq_result i_result (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rd_sel_i   (rd_sel),
    .head_key_i (head_key),
    .count_i    (count),
    .full_i     (full),
    .empty_i    (empty),
    .op_err_i   (op_err),
    .enq_i      (enq_req),
    .err_clr_i  (err_clr),
    .prdata_o   (prdata_o),
    .pslverr_o  (pslverr_o)
  );

endmodule

`default_nettype wire

//--- rtl/pq_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "pq_defs.svh"

module pq_result import pq_pkg::*; (
  input  wire                    clk,
  input  wire                    rst_n_i,
  input  wire apb_addr_t         rd_sel_i,
  input  wire key_t              head_key_i,
  input  wire count_t            count_i,
  input  wire                    full_i,
  input  wire                    empty_i,
  input  wire                    op_err_i,
  input  wire                    enq_i,
  input  wire                    err_clr_i,
  output logic [`PQ_APB_DW-1:0]  prdata_o,
  output logic                   pslverr_o
);

  logic [1:0] err_q;

  ////////////////////
  // Sticky errors
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      err_q <= '0;
    end else if (err_clr_i) begin
      err_q <= '0;
    end else if (op_err_i) begin
      // Only a full queue refuses an enqueue, only an empty one a dequeue
      if (full_i) begin
        err_q[`PQ_ERR_FULL_BIT] <= 1'b1;
      end
      if (empty_i) begin
        err_q[`PQ_ERR_EMPTY_BIT] <= 1'b1;
      end
    end
  end

  ////////////////////
  // Read data
  ////////////////////

  always_comb begin
    prdata_o = '0;
    case (rd_sel_i)
      `PQ_ADDR_DEQ: begin
        prdata_o[`PQ_KEY_W-1:0] = head_key_i;
      end
      `PQ_ADDR_STATUS: begin
        prdata_o[$bits(count_t)-1:0]  = count_i;
        prdata_o[`PQ_STAT_FULL_BIT]  = full_i;
        prdata_o[`PQ_STAT_EMPTY_BIT] = empty_i;
      end
      `PQ_ADDR_ERR: begin
        prdata_o[1:0] = err_q;
      end
      default: begin
        prdata_o = '0;
      end
    endcase
  end

  // Refused operations end with an error response
  assign pslverr_o = op_err_i;

endmodule

`default_nettype wire

//--- rtl/pq_chain.sv
`timescale 1ns/1ps
`default_nettype none

`include "pq_defs.svh"

module pq_chain import pq_pkg::*; (
  input  wire       clk,
  input  wire       rst_n_i,
  input  wire       enq_i,
  input  wire       deq_i,
  input  wire key_t enq_key_i,
  output logic      op_ready_o,
  output key_t      head_key_o,
  output logic      head_valid_o,
  output count_t    count_o,
  output logic      full_o,
  output logic      empty_o
);

  // Index i feeds node i and index PQ_DEPTH leaves the tail
  logic enq_tok     [`PQ_DEPTH+1];
  key_t enq_tok_key [`PQ_DEPTH+1];
  logic deq_tok     [`PQ_DEPTH+1];
  key_t node_key    [`PQ_DEPTH];
  logic node_valid  [`PQ_DEPTH];
  key_t rt_key      [`PQ_DEPTH];
  logic rt_valid    [`PQ_DEPTH];
  logic busy_q;
  count_t cnt_q;

  assign enq_tok[0]     = enq_i;
  assign enq_tok_key[0] = enq_key_i;
  assign deq_tok[0]     = deq_i;

  for (genvar i = 0; i < `PQ_DEPTH; i++) begin : g_node
    if (i == `PQ_DEPTH-1) begin : g_tail
      assign rt_key[i]   = '0;
      assign rt_valid[i] = 1'b0;
    end else begin : g_link
      assign rt_key[i]   = node_key[i+1];
      assign rt_valid[i] = node_valid[i+1];
    end

    pq_node i_node (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .enq_in_i   (enq_tok[i]),
      .enq_key_i  (enq_tok_key[i]),
      .deq_in_i   (deq_tok[i]),
      .rt_key_i   (rt_key[i]),
      .rt_valid_i (rt_valid[i]),
      .enq_out_o  (enq_tok[i+1]),
      .enq_key_o  (enq_tok_key[i+1]),
      .deq_out_o  (deq_tok[i+1]),
      .key_o      (node_key[i]),
      .valid_o    (node_valid[i])
    );
  end

  ////////////////////
  // Pacing and count
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      busy_q <= enq_i | deq_i;
      if (enq_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (deq_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // One idle cycle after every issue
  assign op_ready_o   = ~busy_q;
  assign head_key_o   = node_key[0];
  assign head_valid_o = node_valid[0];
  assign count_o      = cnt_q;
  assign full_o       = (cnt_q == count_t'(`PQ_DEPTH));
  assign empty_o      = (cnt_q == '0);

  a_count_max: assert property (@(posedge clk) disable iff (!rst_n_i)
    cnt_q <= count_t'(`PQ_DEPTH))
    else $error("count above depth");

  // A key leaving the tail would be lost
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
    !enq_tok[`PQ_DEPTH])
    else $error("key %0h dropped off the tail", enq_tok_key[`PQ_DEPTH]);

endmodule

`default_nettype wire

//--- rtl/pq_node.sv
`timescale 1ns/1ps
`default_nettype none

module pq_node import pq_pkg::*; (
  input  wire       clk,
  input  wire       rst_n_i,
  input  wire       enq_in_i,
  input  wire key_t enq_key_i,
  input  wire       deq_in_i,
  input  wire key_t rt_key_i,
  input  wire       rt_valid_i,
  output logic      enq_out_o,
  output key_t      enq_key_o,
  output logic      deq_out_o,
  output key_t      key_o,
  output logic      valid_o
);

  key_t key_q;
  logic valid_q;
  key_t pass_key_q;
  key_t keep_key;
  key_t pass_key;
  logic pass;
  logic load;
  logic pull;

  pq_node_ctrl i_ctrl (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .enq_in_i  (enq_in_i),
    .deq_in_i  (deq_in_i),
    .pass_i    (pass),
    .enq_out_o (enq_out_o),
    .deq_out_o (deq_out_o),
    .load_o    (load),
    .pull_o    (pull)
  );

  pq_value_router i_router (
    .stored_key_i   (key_q),
    .stored_valid_i (valid_q),
    .in_key_i       (enq_key_i),
    .keep_key_o     (keep_key),
    .pass_key_o     (pass_key),
    .pass_o         (pass)
  );

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (pull) begin
      valid_q <= rt_valid_i;
    end
  end

  // Stored key and the key that moves right
  always_ff @(posedge clk) begin
    if (load) begin
      key_q <= keep_key;
    end else if (pull) begin
      key_q <= rt_key_i;
    end
    if (load && pass) begin
      pass_key_q <= pass_key;
    end
  end

  assign enq_key_o = pass_key_q;
  assign key_o     = key_q;
  assign valid_o   = valid_q;

endmodule

`default_nettype wire

//--- rtl/pq_node_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pq_node_ctrl import pq_pkg::*; (
  input  wire  clk,
  input  wire  rst_n_i,
  input  wire  enq_in_i,
  input  wire  deq_in_i,
  input  wire  pass_i,
  output logic enq_out_o,
  output logic deq_out_o,
  output logic load_o,
  output logic pull_o
);

  node_state_e state_q;
  node_state_e state_d;

  // Each state lasts one cycle and emits the token to the right
  always_comb begin
    state_d = st_idle;
    if (enq_in_i && pass_i) begin
      state_d = st_enq_pass;
    end else if (deq_in_i) begin
      state_d = st_deq_pull;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Register updates happen on the arrival edge
  assign load_o = enq_in_i;
  assign pull_o = deq_in_i;

  assign enq_out_o = (state_q == st_enq_pass);
  assign deq_out_o = (state_q == st_deq_pull);

  ////////////////////
  // Checks
  ////////////////////

  // Issue pacing upstream keeps tokens two cycles apart at every node
  a_token_gap: assert property (@(posedge clk) disable iff (!rst_n_i)
    (enq_in_i || deq_in_i) |=> !(enq_in_i || deq_in_i))
    else $error("tokens on consecutive cycles");

  a_token_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(enq_in_i && deq_in_i))
    else $error("enqueue and dequeue tokens met at a node");

endmodule

`default_nettype wire

//--- rtl/pq_value_router.sv
`timescale 1ns/1ps
`default_nettype none

module pq_value_router import pq_pkg::*; (
  input  wire key_t stored_key_i,
  input  wire       stored_valid_i,
  input  wire key_t in_key_i,
  output key_t      keep_key_o,
  output key_t      pass_key_o,
  output logic      pass_o
);

  logic in_smaller;

  // Ties keep the stored key, so equal keys leave in arrival order
  assign in_smaller = in_key_i < stored_key_i;

  always_comb begin
    if (!stored_valid_i) begin
      // Empty node takes the key and the token dies here
      keep_key_o = in_key_i;
      pass_key_o = in_key_i;
      pass_o     = 1'b0;
    end else if (in_smaller) begin
      keep_key_o = in_key_i;
      pass_key_o = stored_key_i;
      pass_o     = 1'b1;
    end else begin
      keep_key_o = stored_key_i;
      pass_key_o = in_key_i;
      pass_o     = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/pq_apb_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "pq_defs.svh"

module pq_apb_decode import pq_pkg::*; (
  input  wire            clk,
  input  wire            rst_n_i,
  input  wire            psel_i,
  input  wire            penable_i,
  input  wire            pwrite_i,
  input  wire apb_addr_t paddr_i,
  input  wire key_t      pwdata_i,
  input  wire            op_ready_i,
  input  wire            full_i,
  input  wire            empty_i,
  output logic           enq_o,
  output logic           deq_o,
  output logic           err_clr_o,
  output apb_addr_t      rd_sel_o,
  output logic           pready_o,
  output logic           op_err_o
);

  logic access;
  logic wr_data;
  logic rd_deq;

  // Setup cycles are ignored
  assign access  = psel_i & penable_i;
  assign wr_data = access & pwrite_i & (paddr_i == `PQ_ADDR_DATA);
  assign rd_deq  = access & ~pwrite_i & (paddr_i == `PQ_ADDR_DEQ);

  always_comb begin
    enq_o     = 1'b0;
    deq_o     = 1'b0;
    err_clr_o = 1'b0;
    op_err_o  = 1'b0;
    pready_o  = 1'b0;
    if (wr_data || rd_deq) begin
      // Queue operations stall until the chain can take one
      pready_o = op_ready_i;
      if (op_ready_i) begin
        if (wr_data) begin
          enq_o    = ~full_i;
          op_err_o = full_i;
        end else begin
          deq_o    = ~empty_i;
          op_err_o = empty_i;
        end
      end
    end else if (access) begin
      pready_o  = 1'b1;
      err_clr_o = pwrite_i & (paddr_i == `PQ_ADDR_ERR);
    end
  end

  // Read mux follows the address directly
  assign rd_sel_o = paddr_i;

  ////////////////////
  // Checks
  ////////////////////

  // The chain latches the bus data on this very edge
  a_key_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    enq_o |-> !$isunknown(pwdata_i))
    else $error("enqueue with unknown key");

endmodule

`default_nettype wire

//--- rtl/pq_pkg.sv
`default_nettype none

`include "pq_defs.svh"

package pq_pkg;

  ////////////////////
  // Data types
  ////////////////////

  // Key held by one node
  typedef logic [`PQ_KEY_W-1:0] key_t;

  // Fill count that can reach PQ_DEPTH itself
  typedef logic [$clog2(`PQ_DEPTH+1)-1:0] count_t;

  // Register offset on APB
  typedef logic [3:0] apb_addr_t;

  ////////////////////
  // Node controller
  ////////////////////

  typedef enum logic [1:0] {
    st_idle,
    st_enq_pass,
    st_deq_pull
  } node_state_e;

endpackage

`default_nettype wire

//--- include/pq_defs.svh
`ifndef PQ_DEFS_SVH
`define PQ_DEFS_SVH

// Queue geometry with one key per node
`define PQ_DEPTH 8
`define PQ_KEY_W 16

// APB data bus width
`define PQ_APB_DW 32

// Register byte offsets
`define PQ_ADDR_DATA   4'h0
`define PQ_ADDR_DEQ    4'h4
`define PQ_ADDR_STATUS 4'h8
`define PQ_ADDR_ERR    4'hC

// STATUS flags above the count in the low bits
`define PQ_STAT_FULL_BIT  8
`define PQ_STAT_EMPTY_BIT 9

// ERR layout
`define PQ_ERR_FULL_BIT  0
`define PQ_ERR_EMPTY_BIT 1

`endif
